//--- aud_speed.f
source/aud_pkg.sv
source/aud_wb_if.sv
source/aud_rec_path.sv
source/aud_step_div.sv
source/aud_play_path.sv
source/aud_bus_arbiter.sv
source/aud_speed_top.sv
verif/aud_sram_model.sv
verif/aud_speed_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the audio speed engine testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --Wno-fatal --top-module aud_speed_tb \
	-f aud_speed.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vaud_speed_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

//--- source/aud_bus_arbiter.sv
`timescale 1ns/1ns

module aud_bus_arbiter (
	input                                i_clk,
	input                                i_rst_n,
	aud_wb_if.slave                      rec_wb,
	aud_wb_if.slave                      play_wb,
	output logic                         o_wb_cyc,
	output logic                         o_wb_stb,
	output logic                         o_wb_we,
	output logic [aud_pkg::ADDR_W-1:0]   o_wb_adr,
	output logic [aud_pkg::SAMPLE_W-1:0] o_wb_dat,
	input        [aud_pkg::SAMPLE_W-1:0] i_wb_dat,
	input                                i_wb_ack
);

	logic lock_r;   // a granted cycle is still open.
	logic gnt_r;    // set while play owns the open cycle.
	logic sel_play;

	// a free bus goes to record first, an open cycle keeps its owner.
	assign sel_play = lock_r ? gnt_r : (!rec_wb.cyc && play_wb.cyc);

	always_comb begin
		if (sel_play) begin
			o_wb_cyc = play_wb.cyc;
			o_wb_stb = play_wb.stb;
			o_wb_we  = play_wb.we;
			o_wb_adr = play_wb.adr;
			o_wb_dat = play_wb.dat_w;
		end else begin
			o_wb_cyc = rec_wb.cyc;
			o_wb_stb = rec_wb.stb;
			o_wb_we  = rec_wb.we;
			o_wb_adr = rec_wb.adr;
			o_wb_dat = rec_wb.dat_w;
		end
	end

	assign rec_wb.ack    = i_wb_ack && !sel_play;
	assign play_wb.ack   = i_wb_ack && sel_play;
	assign rec_wb.dat_r  = sel_play ? '0 : i_wb_dat;
	assign play_wb.dat_r = sel_play ? i_wb_dat : '0;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lock_r <= 1'b0;
			gnt_r  <= 1'b0;
		end else begin
			lock_r <= o_wb_cyc && !i_wb_ack; // released by ack or a dropped cycle.
			gnt_r  <= sel_play;
		end
	end

endmodule

//--- source/aud_pkg.sv
package aud_pkg;

	localparam int SAMPLE_W   = 16; // audio sample width.
	localparam int ADDR_W     = 20; // word address of the sample memory.
	localparam int SPEED_W    = 4;
	localparam int RATIO_W    = 4;  // skip or stretch factor.
	localparam int DIV_CYCLES = 16; // one quotient bit per cycle.
	localparam int DIV_CNT_W  = $clog2(DIV_CYCLES + 1);

	// the top speed code bit selects fast play and the bits below it give the ratio.
	localparam int SPEED_FAST_BIT = 3;

	// slow play stretches by this base minus the low speed bits.
	localparam int STRETCH_BASE = 9;

endpackage

//--- source/aud_play_path.sv
`timescale 1ns/1ns

module aud_play_path (
	input                                i_clk,
	input                                i_rst_n,
	input                                i_clear,
	input                                i_sample_tick,
	input                                i_play_en,
	input        [aud_pkg::SPEED_W-1:0]  i_speed,
	input                                i_interpol,
	input        [aud_pkg::ADDR_W-1:0]   i_rec_count,
	output logic [aud_pkg::SAMPLE_W-1:0] o_dac_data,
	output logic                         o_dac_valid,
	output logic                         o_play_end,
	aud_wb_if.master                     wb,
	output logic                         o_div_start,
	output logic [aud_pkg::SAMPLE_W-1:0] o_div_dividend,
	output logic [aud_pkg::RATIO_W-1:0]  o_div_divisor,
	input        [aud_pkg::SAMPLE_W-1:0] i_div_quotient,
	input                                i_div_done
);

	logic                               fast;
	logic [aud_pkg::SPEED_FAST_BIT-1:0] low;
	logic [aud_pkg::SPEED_FAST_BIT-1:0] low_nz;
	logic [aud_pkg::RATIO_W-1:0]        skip;
	logic [aud_pkg::RATIO_W-1:0]        stretch;
	logic [aud_pkg::RATIO_W-1:0]        phase_nxt;
	logic                               have_data;
	logic [aud_pkg::SAMPLE_W:0]         diff;
	logic [aud_pkg::SAMPLE_W:0]         diff_neg;
	logic [aud_pkg::SAMPLE_W-1:0]       diff_abs;
	logic [aud_pkg::SAMPLE_W-1:0]       step_w;

	logic                         cyc_r;
	logic                         div_wait_r;
	logic                         div_start_r;
	logic                         valid_r;
	logic                         end_r;
	logic                         drain_r; // flat segment of the last sample is out.
	logic [aud_pkg::ADDR_W-1:0]   addr_r;
	logic [aud_pkg::RATIO_W-1:0]  phase_r; // tick index within a segment.
	logic [aud_pkg::SAMPLE_W-1:0] dac_r;
	logic [aud_pkg::SAMPLE_W-1:0] cur_r;   // newest fetched sample.
	logic [aud_pkg::SAMPLE_W-1:0] step_r;
	logic [aud_pkg::SAMPLE_W-1:0] abs_r;
	logic                         sign_r;

	assign fast      = i_speed[aud_pkg::SPEED_FAST_BIT];
	assign low       = i_speed[aud_pkg::SPEED_FAST_BIT-1:0];
	assign low_nz    = (low == '0) ? low + 1'b1 : low;
	assign skip      = (aud_pkg::RATIO_W)'(low) + 1'b1;
	assign stretch   = (aud_pkg::RATIO_W)'(aud_pkg::STRETCH_BASE) - (aud_pkg::RATIO_W)'(low_nz);
	assign phase_nxt = phase_r + 1'b1;
	assign have_data = (addr_r < i_rec_count);

	// sign-extended difference from the current sample to the new one.
	assign diff     = {wb.dat_r[aud_pkg::SAMPLE_W-1], wb.dat_r}
	                - {cur_r[aud_pkg::SAMPLE_W-1], cur_r};
	assign diff_neg = '0 - diff;
	assign diff_abs = diff[aud_pkg::SAMPLE_W] ? diff_neg[aud_pkg::SAMPLE_W-1:0]
	                                          : diff[aud_pkg::SAMPLE_W-1:0];
	assign step_w   = sign_r ? '0 - i_div_quotient : i_div_quotient;

	assign wb.cyc   = cyc_r;
	assign wb.stb   = cyc_r;
	assign wb.we    = 1'b0;
	assign wb.adr   = addr_r;
	assign wb.dat_w = '0;

	assign o_dac_data     = dac_r;
	assign o_dac_valid    = valid_r;
	assign o_play_end     = end_r;
	assign o_div_start    = div_start_r;
	assign o_div_dividend = abs_r;
	assign o_div_divisor  = stretch;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cyc_r       <= 1'b0;
			div_wait_r  <= 1'b0;
			div_start_r <= 1'b0;
			valid_r     <= 1'b0;
			end_r       <= 1'b0;
			drain_r     <= 1'b0;
			addr_r      <= '0;
			phase_r     <= '0;
			dac_r       <= '0;
			cur_r       <= '0;
			step_r      <= '0;
		end else if (i_clear) begin
			cyc_r       <= 1'b0;
			div_wait_r  <= 1'b0;
			div_start_r <= 1'b0;
			valid_r     <= 1'b0;
			end_r       <= 1'b0;
			drain_r     <= 1'b0;
			addr_r      <= '0;
			phase_r     <= '0;
			dac_r       <= '0;
			cur_r       <= '0;
			step_r      <= '0;
		end else begin
			valid_r     <= 1'b0;
			div_start_r <= 1'b0;
			if (cyc_r) begin
				if (wb.ack) begin
					cyc_r <= 1'b0;
					if (fast) begin
						dac_r   <= wb.dat_r;
						valid_r <= 1'b1;
						addr_r  <= addr_r + skip;
					end else begin
						cur_r  <= wb.dat_r;
						dac_r  <= cur_r; // segment starts at the previous sample.
						addr_r <= addr_r + 1'b1;
						if (i_interpol) begin
							div_start_r <= 1'b1;
							div_wait_r  <= 1'b1;
						end else begin
							step_r  <= '0;
							valid_r <= 1'b1;
						end
					end
				end
			end else if (div_wait_r) begin
				if (i_div_done) begin
					div_wait_r <= 1'b0;
					step_r     <= step_w;
					valid_r    <= 1'b1;
				end
			end else if (!i_play_en) begin
				addr_r  <= '0;
				phase_r <= '0;
				end_r   <= 1'b0;
				drain_r <= 1'b0;
				cur_r   <= '0;
				step_r  <= '0;
			end else if (i_sample_tick && !end_r) begin
				if (fast) begin
					if (have_data) begin
						cyc_r <= 1'b1;
					end else begin
						end_r <= 1'b1;
					end
				end else if (phase_r != '0) begin
					dac_r   <= dac_r + step_r;
					valid_r <= 1'b1;
					phase_r <= (phase_nxt >= stretch) ? '0 : phase_nxt;
				end else if (have_data) begin
					cyc_r   <= 1'b1;
					phase_r <= 1'b1;
				end else if (!drain_r) begin
					// Memory ran out; hold the last sample for one more segment.
					drain_r <= 1'b1;
					dac_r   <= cur_r;
					step_r  <= '0;
					valid_r <= 1'b1;
					phase_r <= 1'b1;
				end else begin
					end_r <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (cyc_r && wb.ack) begin
			abs_r  <= diff_abs;
			sign_r <= diff[aud_pkg::SAMPLE_W];
		end
	end

endmodule

//--- source/aud_rec_path.sv
`timescale 1ns/1ns

module aud_rec_path (
	input                                i_clk,
	input                                i_rst_n,
	input                                i_clear,
	input                                i_sample_tick,
	input                                i_rec_en,
	input        [aud_pkg::SAMPLE_W-1:0] i_adc_data,
	output logic [aud_pkg::ADDR_W-1:0]   o_rec_count,
	aud_wb_if.master                     wb
);

	logic                         cyc_r;
	logic [aud_pkg::ADDR_W-1:0]   count_r;
	logic [aud_pkg::SAMPLE_W-1:0] sample_r;

	assign wb.cyc      = cyc_r;
	assign wb.stb      = cyc_r;
	assign wb.we       = 1'b1; // this side only writes.
	assign wb.adr      = count_r; // count doubles as the next free word.
	assign wb.dat_w    = sample_r;
	assign o_rec_count = count_r;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cyc_r   <= 1'b0;
			count_r <= '0;
		end else if (i_clear) begin
			cyc_r   <= 1'b0;
			count_r <= '0;
		end else if (cyc_r) begin
			if (wb.ack) begin
				cyc_r   <= 1'b0;
				count_r <= count_r + 1'b1;
			end
		end else if (i_sample_tick && i_rec_en) begin
			cyc_r <= 1'b1;
		end
	end

	// a tick during a write is dropped, so the sample stays stable.
	always_ff @(posedge i_clk) begin
		if (i_sample_tick && !cyc_r) begin
			sample_r <= i_adc_data;
		end
	end

endmodule

//--- source/aud_speed_top.sv
`timescale 1ns/1ns

module aud_speed_top (
	input                                i_clk,
	input                                i_rst_n,
	input                                i_clear,
	input                                i_sample_tick,
	input                                i_rec_en,
	input                                i_play_en,
	input        [aud_pkg::SPEED_W-1:0]  i_speed,
	input                                i_interpol,
	input        [aud_pkg::SAMPLE_W-1:0] i_adc_data,
	output logic [aud_pkg::SAMPLE_W-1:0] o_dac_data,
	output logic                         o_dac_valid,
	output logic [aud_pkg::ADDR_W-1:0]   o_rec_count,
	output logic                         o_play_end,
	output logic                         o_wb_cyc,
	output logic                         o_wb_stb,
	output logic                         o_wb_we,
	output logic [aud_pkg::ADDR_W-1:0]   o_wb_adr,
	output logic [aud_pkg::SAMPLE_W-1:0] o_wb_dat,
	input        [aud_pkg::SAMPLE_W-1:0] i_wb_dat,
	input                                i_wb_ack
);

	logic                         div_start;
	logic [aud_pkg::SAMPLE_W-1:0] div_dividend;
	logic [aud_pkg::RATIO_W-1:0]  div_divisor;
	logic [aud_pkg::SAMPLE_W-1:0] div_quotient;
	logic                         div_done;

	aud_wb_if rec_bus ();
	aud_wb_if play_bus ();

	aud_rec_path i_aud_rec_path (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_clear       (i_clear),
		.i_sample_tick (i_sample_tick),
		.i_rec_en      (i_rec_en),
		.i_adc_data    (i_adc_data),
		.o_rec_count   (o_rec_count),
		.wb            (rec_bus.master)
	);

	aud_play_path i_aud_play_path (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_clear        (i_clear),
		.i_sample_tick  (i_sample_tick),
		.i_play_en      (i_play_en),
		.i_speed        (i_speed),
		.i_interpol     (i_interpol),
		.i_rec_count    (o_rec_count),
		.o_dac_data     (o_dac_data),
		.o_dac_valid    (o_dac_valid),
		.o_play_end     (o_play_end),
		.wb             (play_bus.master),
		.o_div_start    (div_start),
		.o_div_dividend (div_dividend),
		.o_div_divisor  (div_divisor),
		.i_div_quotient (div_quotient),
		.i_div_done     (div_done)
	);

	aud_step_div i_aud_step_div (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (div_start),
		.i_dividend (div_dividend),
		.i_divisor  (div_divisor),
		.o_quotient (div_quotient),
		.o_done     (div_done)
	);

	aud_bus_arbiter i_aud_bus_arbiter (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.rec_wb   (rec_bus.slave),
		.play_wb  (play_bus.slave),
		.o_wb_cyc (o_wb_cyc),
		.o_wb_stb (o_wb_stb),
		.o_wb_we  (o_wb_we),
		.o_wb_adr (o_wb_adr),
		.o_wb_dat (o_wb_dat),
		.i_wb_dat (i_wb_dat),
		.i_wb_ack (i_wb_ack)
	);

endmodule

//--- source/aud_step_div.sv
`timescale 1ns/1ns

module aud_step_div (
	input                                i_clk,
	input                                i_rst_n,
	input                                i_start,
	input        [aud_pkg::SAMPLE_W-1:0] i_dividend,
	input        [aud_pkg::RATIO_W-1:0]  i_divisor,
	output logic [aud_pkg::SAMPLE_W-1:0] o_quotient,
	output logic                         o_done
);

	logic [aud_pkg::DIV_CNT_W-1:0] cnt_r;
	logic                          done_r;
	logic [aud_pkg::SAMPLE_W-1:0]  quo_r; // dividend shifts out, quotient shifts in.
	logic [aud_pkg::RATIO_W-1:0]   rem_r;
	logic [aud_pkg::RATIO_W-1:0]   dvs_r;
	logic [aud_pkg::RATIO_W:0]     rem_sh;
	logic [aud_pkg::RATIO_W:0]     rem_sub;

	assign rem_sh  = {rem_r, quo_r[aud_pkg::SAMPLE_W-1]};
	assign rem_sub = rem_sh - {1'b0, dvs_r};

	assign o_quotient = quo_r;
	assign o_done     = done_r;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_r  <= '0;
			done_r <= 1'b0;
		end else begin
			done_r <= 1'b0;
			if (i_start) begin
				cnt_r <= (aud_pkg::DIV_CNT_W)'(aud_pkg::DIV_CYCLES);
			end else if (cnt_r != '0) begin
				cnt_r  <= cnt_r - 1'b1;
				done_r <= (cnt_r == 1); // last bit lands now.
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			quo_r <= i_dividend;
			rem_r <= '0;
			dvs_r <= i_divisor;
		end else if (cnt_r != '0) begin
			if (rem_sh >= {1'b0, dvs_r}) begin
				rem_r <= rem_sub[aud_pkg::RATIO_W-1:0];
				quo_r <= {quo_r[aud_pkg::SAMPLE_W-2:0], 1'b1};
			end else begin
				rem_r <= rem_sh[aud_pkg::RATIO_W-1:0]; // restore.
				quo_r <= {quo_r[aud_pkg::SAMPLE_W-2:0], 1'b0};
			end
		end
	end

endmodule

//--- source/aud_wb_if.sv
`timescale 1ns/1ns

interface aud_wb_if;

	logic                         cyc;
	logic                         stb;
	logic                         we;
	logic [aud_pkg::ADDR_W-1:0]   adr;
	logic [aud_pkg::SAMPLE_W-1:0] dat_w;
	logic [aud_pkg::SAMPLE_W-1:0] dat_r;
	logic                         ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

//--- verif/aud_speed_tb.sv
`timescale 1ns/1ns

module aud_speed_tb;

	localparam int          GAP      = 48; // cycles from one tick to the next.
	localparam int          WAIT_MAX = 40;
	localparam int          ROWS     = 28;
	localparam logic [31:0] SEED     = 32'ha5e8_b5ab;

	typedef struct {
		string      name;
		logic [3:0] speed;
		bit         interp;
		bit         rec;
		bit         play;
		bit         clear;
		int         ticks;
	} row_t;

	logic                         i_clk;
	logic                         i_rst_n;
	logic                         i_clear;
	logic                         i_sample_tick;
	logic                         i_rec_en;
	logic                         i_play_en;
	logic [aud_pkg::SPEED_W-1:0]  i_speed;
	logic                         i_interpol;
	logic [aud_pkg::SAMPLE_W-1:0] i_adc_data;
	logic [aud_pkg::SAMPLE_W-1:0] o_dac_data;
	logic                         o_dac_valid;
	logic [aud_pkg::ADDR_W-1:0]   o_rec_count;
	logic                         o_play_end;
	logic                         wb_cyc;
	logic                         wb_stb;
	logic                         wb_we;
	logic [aud_pkg::ADDR_W-1:0]   wb_adr;
	logic [aud_pkg::SAMPLE_W-1:0] wb_dat_w;
	logic [aud_pkg::SAMPLE_W-1:0] wb_dat_r;
	logic                         wb_ack;
	logic [1:0]                   sram_delay;

	logic [31:0]                  sample_state = SEED;
	logic [31:0]                  delay_state  = SEED;
	logic [aud_pkg::SAMPLE_W-1:0] ref_mem [0:4095]; // own copy of the recording.
	int                           ref_count;
	int                           sample_idx;
	row_t                         rows [ROWS];

	aud_speed_top i_aud_speed_top (
		.i_clk (i_clk), .i_rst_n (i_rst_n), .i_clear (i_clear),
		.i_sample_tick (i_sample_tick), .i_rec_en (i_rec_en), .i_play_en (i_play_en),
		.i_speed (i_speed), .i_interpol (i_interpol), .i_adc_data (i_adc_data),
		.o_dac_data (o_dac_data), .o_dac_valid (o_dac_valid), .o_rec_count (o_rec_count),
		.o_play_end (o_play_end), .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_we (wb_we),
		.o_wb_adr (wb_adr), .o_wb_dat (wb_dat_w), .i_wb_dat (wb_dat_r), .i_wb_ack (wb_ack)
	);

	aud_sram_model i_sram (
		.i_clk (i_clk), .i_rst_n (i_rst_n), .i_cyc (wb_cyc), .i_stb (wb_stb), .i_we (wb_we),
		.i_adr (wb_adr), .i_dat (wb_dat_w), .i_delay (sram_delay), .o_dat (wb_dat_r),
		.o_ack (wb_ack)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s >> 1;
		if (s[0]) begin
			lfsr_next = lfsr_next ^ 32'hb4bc_d35c;
		end
	endfunction

	task automatic draw_sample(output logic [aud_pkg::SAMPLE_W-1:0] v);
		v = '0;
		for (int b = 0; b < aud_pkg::SAMPLE_W; b++) begin
			v            = {v[aud_pkg::SAMPLE_W-2:0], sample_state[0]};
			sample_state = lfsr_next(sample_state);
		end
	endtask

	// a fresh two-bit ack delay every cycle.
	always @(posedge i_clk) begin : delay_gen
		logic [1:0] d;
		d           = {delay_state[0], 1'b0};
		delay_state = lfsr_next(delay_state);
		d[0]        = delay_state[0];
		delay_state = lfsr_next(delay_state);
		sram_delay <= d;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic compare_sample(input string name, input logic [aud_pkg::SAMPLE_W-1:0] exp,
			input logic [aud_pkg::SAMPLE_W-1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic compare_count(input string name, input logic [aud_pkg::ADDR_W-1:0] exp,
			input logic [aud_pkg::ADDR_W-1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
		end
	endtask

	// drive one tick, wait for every expected response and hold the tick spacing.
	task automatic apply_tick(input string name, input logic [aud_pkg::SAMPLE_W-1:0] adc,
			input bit exp_valid, input logic [aud_pkg::SAMPLE_W-1:0] exp_data, input bit exp_end);
		int                           cycles;
		bit                           got_valid;
		logic [aud_pkg::SAMPLE_W-1:0] got_data;
		got_valid = 1'b0;
		got_data  = '0;
		@(posedge i_clk);
		i_sample_tick <= 1'b1;
		i_adc_data    <= adc;
		@(posedge i_clk);
		i_sample_tick <= 1'b0;
		cycles = 1;
		while (!((got_valid || !exp_valid) && o_play_end == exp_end
				&& o_rec_count == aud_pkg::ADDR_W'(ref_count))) begin
			if (cycles >= WAIT_MAX) begin
				abort_run($sformatf("%s: the DUT did not respond to a sample tick in time", name));
			end
			@(posedge i_clk);
			cycles++;
			if (o_dac_valid) begin
				if (got_valid || !exp_valid) begin
					abort_run($sformatf("%s: o_dac_valid came when none was due", name));
				end
				got_valid = 1'b1;
				got_data  = o_dac_data;
			end
		end
		while (cycles < GAP) begin
			@(posedge i_clk);
			cycles++;
			if (o_dac_valid) begin
				abort_run($sformatf("%s: o_dac_valid came when none was due", name));
			end
		end
		if (exp_valid) begin
			compare_sample({name, " dac"}, exp_data, got_data);
		end
		compare_count({name, " rec count"}, aud_pkg::ADDR_W'(ref_count), o_rec_count);
		compare_flag({name, " play end"}, exp_end, o_play_end);
	endtask

	task automatic run_row(input row_t row);
		int                           ratio;
		int                           addr;
		int                           phase;
		int                           seg_step;
		int                           diff;
		int                           mag;
		bit                           drained;
		bit                           ended;
		bit                           exp_valid;
		logic [aud_pkg::SAMPLE_W-1:0] cur;
		logic [aud_pkg::SAMPLE_W-1:0] seg_prev;
		logic [aud_pkg::SAMPLE_W-1:0] exp_data;
		logic [aud_pkg::SAMPLE_W-1:0] adc;
		if (row.clear) begin
			@(posedge i_clk);
			i_clear <= 1'b1;
			@(posedge i_clk);
			i_clear <= 1'b0;
			@(posedge i_clk);
			ref_count = 0;
			compare_sample({row.name, " dac after clear"}, '0, o_dac_data);
			compare_count({row.name, " rec count after clear"}, '0, o_rec_count);
			compare_flag({row.name, " play end after clear"}, 1'b0, o_play_end);
			compare_flag({row.name, " dac valid after clear"}, 1'b0, o_dac_valid);
			compare_flag({row.name, " bus cycle after clear"}, 1'b0, wb_cyc);
			compare_flag({row.name, " bus strobe after clear"}, 1'b0, wb_stb);
		end
		i_rec_en  <= 1'b0;
		i_play_en <= 1'b0;
		repeat (2) @(posedge i_clk);
		i_speed    <= row.speed;
		i_interpol <= row.interp;
		i_rec_en   <= row.rec;
		i_play_en  <= row.play;
		if (row.speed[3]) begin
			ratio = int'(row.speed[2:0]) + 1;
		end else begin
			ratio = 9 - ((row.speed[2:0] == 0) ? 1 : int'(row.speed[2:0]));
		end
		{addr, phase, seg_step, drained, ended, cur, seg_prev} = '0;
		for (int t = 0; t < row.ticks; t++) begin
			exp_valid = 1'b0;
			exp_data  = '0;
			if (row.play && !ended) begin
				if (row.speed[3]) begin
					if (addr < ref_count) begin
						exp_valid = 1'b1;
						exp_data  = ref_mem[addr];
						addr      = addr + ratio;
					end else begin
						ended = 1'b1;
					end
				end else if (phase == 0 && (addr < ref_count || !drained)) begin
					seg_prev = cur;
					seg_step = 0;
					if (addr < ref_count) begin
						cur = ref_mem[addr];
						addr++;
						diff = int'($signed(cur)) - int'($signed(seg_prev));
						mag  = ((diff < 0) ? -diff : diff) / ratio;
						if (row.interp) begin
							seg_step = (diff < 0) ? -mag : mag;
						end
					end else begin
						drained = 1'b1; // last sample held for one segment.
					end
					exp_valid = 1'b1;
					exp_data  = seg_prev;
					phase     = 1;
				end else if (phase != 0) begin
					exp_valid = 1'b1;
					exp_data  = 16'(int'($signed(seg_prev)) + phase * seg_step);
					phase     = (phase + 1 == ratio) ? 0 : phase + 1;
				end else begin
					ended = 1'b1;
				end
			end
			adc = '0;
			if (row.rec) begin
				if (sample_idx % 16 == 5) begin
					adc = 16'h7fff;
				end else if (sample_idx % 16 == 6) begin
					adc = 16'h8000; // full-scale fall.
				end else begin
					draw_sample(adc);
				end
				sample_idx++;
				ref_mem[ref_count] = adc;
				ref_count++;
			end
			apply_tick($sformatf("%s tick %0d", row.name, t), adc, exp_valid, exp_data, ended);
		end
	endtask

	initial begin
		rows[0]  = '{"record_64", 4'd0, 1'b0, 1'b1, 1'b0, 1'b0, 64};
		rows[1]  = '{"fast_x1", 4'd8, 1'b0, 1'b0, 1'b1, 1'b0, 65};
		rows[2]  = '{"fast_x2", 4'd9, 1'b0, 1'b0, 1'b1, 1'b0, 33};
		rows[3]  = '{"fast_x3", 4'd10, 1'b0, 1'b0, 1'b1, 1'b0, 23};
		rows[4]  = '{"fast_x4", 4'd11, 1'b0, 1'b0, 1'b1, 1'b0, 17};
		rows[5]  = '{"fast_x5", 4'd12, 1'b0, 1'b0, 1'b1, 1'b0, 14};
		rows[6]  = '{"fast_x6", 4'd13, 1'b0, 1'b0, 1'b1, 1'b0, 12};
		rows[7]  = '{"fast_x7", 4'd14, 1'b0, 1'b0, 1'b1, 1'b0, 11};
		rows[8]  = '{"fast_x8", 4'd15, 1'b0, 1'b0, 1'b1, 1'b0, 9};
		for (int c = 1; c <= 7; c++) begin
			rows[8 + c]  = '{$sformatf("hold_code%0d", c), 4'(c), 1'b0, 1'b0, 1'b1, 1'b0,
			                 65 * (9 - c) + 1};
			rows[15 + c] = '{$sformatf("linear_code%0d", c), 4'(c), 1'b1, 1'b0, 1'b1, 1'b0,
			                 65 * (9 - c) + 1};
		end
		rows[23] = '{"rec_and_fast", 4'd9, 1'b0, 1'b1, 1'b1, 1'b0, 40};
		rows[24] = '{"rec_and_linear", 4'd7, 1'b1, 1'b1, 1'b1, 1'b0, 40};
		rows[25] = '{"fast_to_end", 4'd15, 1'b0, 1'b0, 1'b1, 1'b0, 20};
		rows[26] = '{"clear_record", 4'd0, 1'b0, 1'b1, 1'b0, 1'b1, 16};
		rows[27] = '{"play_after_clear", 4'd8, 1'b0, 1'b0, 1'b1, 1'b0, 17};
		i_rst_n       = 1'b0;
		i_clear       = 1'b0;
		i_sample_tick = 1'b0;
		i_rec_en      = 1'b0;
		i_play_en     = 1'b0;
		i_speed       = '0;
		i_interpol    = 1'b0;
		i_adc_data    = '0;
		ref_count     = 0;
		sample_idx    = 0;
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;
		for (int r = 0; r < ROWS; r++) begin
			run_row(rows[r]);
			if (rows[r].rec) begin
				for (int a = 0; a < ref_count; a++) begin
					compare_sample($sformatf("%s memory word %0d", rows[r].name, a), ref_mem[a],
						i_sram.mem[a]);
				end
			end
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- verif/aud_sram_model.sv
`timescale 1ns/1ns

module aud_sram_model #(
	parameter int DEPTH_W = 12
) (
	input                                i_clk,
	input                                i_rst_n,
	input                                i_cyc,
	input                                i_stb,
	input                                i_we,
	input        [aud_pkg::ADDR_W-1:0]   i_adr,
	input        [aud_pkg::SAMPLE_W-1:0] i_dat,
	input        [1:0]                   i_delay,
	output logic [aud_pkg::SAMPLE_W-1:0] o_dat,
	output logic                         o_ack
);

	logic [aud_pkg::SAMPLE_W-1:0] mem [0:(1<<DEPTH_W)-1];
	logic [1:0]                   wait_cnt;

	initial begin
		for (int a = 0; a < (1 << DEPTH_W); a++) begin
			mem[a] = 16'(a * 40503) ^ 16'(a >> 5); // every address bit shows.
		end
	end

	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ack    <= 1'b0;
			o_dat    <= '0;
			wait_cnt <= '0;
		end else begin
			o_ack <= 1'b0;
			if (i_cyc && i_stb && !o_ack) begin
				if (wait_cnt >= i_delay) begin
					o_ack    <= 1'b1;
					wait_cnt <= '0;
					o_dat    <= mem[i_adr[DEPTH_W-1:0]];
					if (i_we) begin
						mem[i_adr[DEPTH_W-1:0]] <= i_dat;
					end
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
		end
	end

endmodule
